//--- src/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// width of a data word and of a byte address.
`define CORE_XLEN 32

// architectural register count.
`define CORE_REG_COUNT 32

// bits needed to index a register.
`define CORE_REG_AW 5

`endif

//--- src/isa_pkg.sv
package isa_pkg;

    // major opcodes of the supported rv32i subset.
    typedef enum logic [6:0] {
        OP_LOAD   = 7'd3,
        OP_STORE  = 7'd35,
        OP_RTYPE  = 7'd51,
        OP_BRANCH = 7'd99
    } opcode_e;

    // alu operation select.
    typedef enum logic [3:0] {
        AND  = 4'd0,
        OR   = 4'd1,
        ADD  = 4'd2,
        SLL  = 4'd3,
        SLT  = 4'd4,
        SLTU = 4'd5,
        SUB  = 4'd6,
        XOR  = 4'd7,
        SRL  = 4'd8,
        SRA  = 4'd9
    } alu_op_e;

    // funct7 pattern that turns add into sub and srl into sra.
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    // r-type funct3 values.
    localparam logic [2:0] F3_ADD_SUB = 3'd0;
    localparam logic [2:0] F3_SLL     = 3'd1;
    localparam logic [2:0] F3_SLT     = 3'd2;
    localparam logic [2:0] F3_SLTU    = 3'd3;
    localparam logic [2:0] F3_XOR     = 3'd4;
    localparam logic [2:0] F3_SRL_SRA = 3'd5;
    localparam logic [2:0] F3_OR      = 3'd6;
    localparam logic [2:0] F3_AND     = 3'd7;

    // funct3 for word-sized lw and sw.
    localparam logic [2:0] F3_WORD = 3'd2;

    // funct3 for beq.
    localparam logic [2:0] F3_BEQ = 3'd0;

endpackage

//--- src/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [`CORE_REG_AW-1:0] reg_idx_t;

    // control bits produced by decode.
    typedef struct packed {
        logic             reg_wr;
        logic             mem_rd;
        logic             mem_wr;
        logic             mem_to_rgs;
        logic             alu_src;
        logic             brnch;
        isa_pkg::alu_op_e alu_op;
    } ctrl_t;

    // fetch to decode.
    typedef struct packed {
        word_t instr;
        word_t pc;
    } ifid_t;

    // decode to execute.
    typedef struct packed {
        word_t    pc;
        word_t    rda;
        word_t    rdb;
        word_t    im_gen;
        reg_idx_t wa;
        ctrl_t    ctrl;
    } idex_t;

endpackage

//--- src/regfile_if.sv
`timescale 1ns/1ps

interface regfile_if;
    import core_pkg::*;

    // read side.
    reg_idx_t ra;
    reg_idx_t rb;
    word_t    rda;
    word_t    rdb;

    // write side driven from write-back.
    reg_idx_t wa;
    word_t    wda;
    logic     reg_wr;

    modport dec (output ra, output rb, input rda, input rdb);

    modport wb (output wa, output wda, output reg_wr);

    modport rf (
        input  ra, input rb, input wa, input wda, input reg_wr,
        output rda, output rdb
    );

endinterface

//--- src/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
    input  core_pkg::word_t    instr,
    regfile_if.dec             rf,
    output core_pkg::ctrl_t    ctrl,
    output core_pkg::word_t    im_gen,
    output core_pkg::reg_idx_t wa
);
    import isa_pkg::*;
    import core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;
    alu_op_e    rtype_op;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = (instr[31:25] == FUNCT7_ALT);

    // operand indices come straight from the fixed fields.
    assign rf.ra = instr[19:15];
    assign rf.rb = instr[24:20];
    assign wa    = instr[11:7];

    // sign-extended immediates per format.
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // alu op for r-type from funct3 and funct7.
    always_comb begin
        rtype_op = ADD;
        case (funct3)
            F3_ADD_SUB: rtype_op = alt ? SUB : ADD;
            F3_SLL:     rtype_op = SLL;
            F3_SLT:     rtype_op = SLT;
            F3_SLTU:    rtype_op = SLTU;
            F3_XOR:     rtype_op = XOR;
            F3_SRL_SRA: rtype_op = alt ? SRA : SRL;
            F3_OR:      rtype_op = OR;
            F3_AND:     rtype_op = AND;
            default:    rtype_op = ADD;
        endcase
    end

    always_comb begin
        ctrl   = '0;
        im_gen = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_wr = 1'b1;
                ctrl.alu_op = rtype_op;
            end
            OP_LOAD: begin
                if (funct3 == F3_WORD) begin
                    ctrl.reg_wr     = 1'b1;
                    ctrl.mem_rd     = 1'b1;
                    ctrl.mem_to_rgs = 1'b1;
                    ctrl.alu_src    = 1'b1;
                    ctrl.alu_op     = ADD;
                    im_gen          = imm_i;
                end
            end
            OP_STORE: begin
                if (funct3 == F3_WORD) begin
                    ctrl.mem_wr  = 1'b1;
                    ctrl.alu_src = 1'b1;
                    ctrl.alu_op  = ADD;
                    im_gen       = imm_s;
                end
            end
            OP_BRANCH: begin
                // equality shows up as a zero difference.
                if (funct3 == F3_BEQ) begin
                    ctrl.brnch  = 1'b1;
                    ctrl.alu_op = SUB;
                    im_gen      = imm_b;
                end
            end
            default: begin
                ctrl   = '0;
                im_gen = '0;
            end
        endcase
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module reg_file (
    input  logic clk,
    input  logic reset,
    regfile_if.rf rf
);
    import core_pkg::*;

    word_t regs [`CORE_REG_COUNT];

    // x0 reads zero, a write in flight is forwarded.
    function automatic word_t read_port(input reg_idx_t idx);
        word_t data;
        if (idx == '0) begin
            data = '0;
        end else if (rf.reg_wr && (rf.wa == idx)) begin
            data = rf.wda;
        end else begin
            data = regs[idx];
        end
        return data;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.reg_wr && (rf.wa != '0)) begin
            regs[rf.wa] <= rf.wda;
        end
    end

    always_comb begin
        rf.rda = read_port(rf.ra);
        rf.rdb = read_port(rf.rb);
    end

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
    input  isa_pkg::alu_op_e op,
    input  core_pkg::word_t  a,
    input  core_pkg::word_t  b,
    output core_pkg::word_t  result
);
    import isa_pkg::*;

    logic [4:0] shamt;

    // only the low five bits count for shifts.
    assign shamt = b[4:0];

    always_comb begin
        result = '0;
        case (op)
            AND: begin
                result = a & b;
            end
            OR: begin
                result = a | b;
            end
            ADD: begin
                result = a + b;
            end
            SUB: begin
                result = a - b;
            end
            XOR: begin
                result = a ^ b;
            end
            SLL: begin
                result = a << shamt;
            end
            SRL: begin
                result = a >> shamt;
            end
            SRA: begin
                result = $signed(a) >>> shamt;
            end
            SLT: begin
                result[0] = ($signed(a) < $signed(b));
            end
            SLTU: begin
                result[0] = (a < b);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- src/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     load_valid,
    input  logic     flush,
    input  payload_t d,
    output payload_t q,
    output logic     valid
);

    // payload moves every cycle, valid says if it counts.
    always_ff @(posedge clk) begin
        q <= d;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else begin
            valid <= load_valid;
        end
    end

endmodule

//--- src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
    input  logic            clk,
    input  logic            reset,
    output core_pkg::word_t imem_addr,
    input  core_pkg::word_t imem_data,
    output core_pkg::word_t dmem_addr,
    output core_pkg::word_t dmem_wdata,
    output logic            dmem_we,
    input  core_pkg::word_t dmem_rdata
);
    import core_pkg::*;

    localparam word_t PC_STEP = word_t'(4);

    word_t    pc;
    word_t    pc_next;
    word_t    br_target;
    logic     br_taken;

    ifid_t    ifid_d;
    ifid_t    ifid_q;
    logic     ifid_valid;

    ctrl_t    dec_ctrl;
    word_t    dec_imm;
    reg_idx_t dec_wa;

    idex_t    idex_d;
    idex_t    idex_q;
    logic     idex_valid;

    word_t    alu_b;
    word_t    alu_result;
    word_t    wb_data;

    regfile_if rf_bus ();

    reg_file u_reg_file (
        .clk   (clk),
        .reset (reset),
        .rf    (rf_bus.rf)
    );

    // fetch.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_next   = br_taken ? br_target : pc + PC_STEP;
    assign imem_addr = pc;
    assign ifid_d    = '{instr: imem_data, pc: pc};

    stage_reg #(.payload_t(ifid_t)) u_ifid (
        .clk        (clk),
        .reset      (reset),
        .load_valid (1'b1),
        .flush      (br_taken),
        .d          (ifid_d),
        .q          (ifid_q),
        .valid      (ifid_valid)
    );

    // decode and register reads.
    decode_unit u_decode (
        .instr  (ifid_q.instr),
        .rf     (rf_bus.dec),
        .ctrl   (dec_ctrl),
        .im_gen (dec_imm),
        .wa     (dec_wa)
    );

    assign idex_d = '{
        pc:     ifid_q.pc,
        rda:    rf_bus.rda,
        rdb:    rf_bus.rdb,
        im_gen: dec_imm,
        wa:     dec_wa,
        ctrl:   dec_ctrl
    };

    stage_reg #(.payload_t(idex_t)) u_idex (
        .clk        (clk),
        .reset      (reset),
        .load_valid (ifid_valid),
        .flush      (br_taken),
        .d          (idex_d),
        .q          (idex_q),
        .valid      (idex_valid)
    );

    // execute.
    assign alu_b = idex_q.ctrl.alu_src ? idex_q.im_gen : idex_q.rdb;

    alu u_alu (
        .op     (idex_q.ctrl.alu_op),
        .a      (idex_q.rda),
        .b      (alu_b),
        .result (alu_result)
    );

    // beq taken when the difference is zero; kills both younger slots.
    assign br_taken  = idex_valid && idex_q.ctrl.brnch && (alu_result == '0);
    assign br_target = idex_q.pc + idex_q.im_gen;

    // memory access with the address held at zero when idle.
    assign dmem_addr  = (idex_q.ctrl.mem_rd || idex_q.ctrl.mem_wr) ? alu_result : '0;
    assign dmem_wdata = idex_q.rdb;
    assign dmem_we    = idex_valid && idex_q.ctrl.mem_wr;

    // write-back at the closing edge of execute.
    assign wb_data       = idex_q.ctrl.mem_to_rgs ? dmem_rdata : alu_result;
    assign rf_bus.wa     = idex_q.wa;
    assign rf_bus.wda    = wb_data;
    assign rf_bus.reg_wr = idex_valid && idex_q.ctrl.reg_wr;

endmodule

//--- dv/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;

    localparam logic [31:0] NOP = 32'h0000_0013;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    logic [31:0] prog_mem [256];
    logic [31:0] prog_len = '0;
    logic [31:0] dmem [256];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          store_idx = 0;
    int          budget = 0;

    cpu_core i_cpu_core (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    always #50 clk = ~clk;

    // word-addressed program with a nop past its end.
    assign imem_data  = ((imem_addr >> 2) < prog_len) ? prog_mem[imem_addr[9:2]] : NOP;
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h",
                               name, actual, expected));
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          c;
        logic [7:0]  tag;
        logic [31:0] a;
        logic [31:0] d;
        // background fill carries its own byte address.
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hc0de_0000 | (32'(i) << 2);
        end
        fd = $fopen("dv/cpu_patterns.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open dv/cpu_patterns.txt for reading");
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                case (tag)
                    "I": begin
                        void'($fscanf(fd, "%h", d));
                        prog_mem[prog_len[7:0]] = d;
                        prog_len = prog_len + 1;
                    end
                    "D": begin
                        void'($fscanf(fd, "%h %h", a, d));
                        dmem[a[9:2]] = d;
                    end
                    "S": begin
                        void'($fscanf(fd, "%h %h", a, d));
                        exp_addr.push_back(a);
                        exp_data.push_back(d);
                    end
                    "C": begin
                        void'($fscanf(fd, "%d", budget));
                    end
                    default: begin
                        // anything else is a note up to the end of the line.
                        c = $fgetc(fd);
                        while (c != 10 && c != -1) begin
                            c = $fgetc(fd);
                        end
                    end
                endcase
            end
            $fclose(fd);
            if (budget == 0) begin
                fail_run("pattern file gives no cycle budget");
            end
        end
    endtask

    // data memory writes and store checks at mid-cycle.
    initial begin
        load_patterns();
        forever begin
            @(negedge clk);
            if (reset) begin
                check("dmem_we", {31'b0, dmem_we}, 32'h0);
            end else if (dmem_we) begin
                if (store_idx >= exp_addr.size()) begin
                    fail_run($sformatf("unexpected extra store of 0x%08h to address 0x%08h",
                                       dmem_wdata, dmem_addr));
                end else begin
                    check("dmem_addr", dmem_addr, exp_addr[store_idx]);
                    check("dmem_wdata", dmem_wdata, exp_data[store_idx]);
                    dmem[dmem_addr[9:2]] = dmem_wdata;
                    store_idx++;
                end
            end
        end
    end

    initial begin
        repeat (10) @(negedge clk);
        check("imem_addr", imem_addr, 32'h0);
        reset <= 1'b0;
        while (store_idx < exp_addr.size()) begin
            @(posedge clk);
        end
        // the closing self-loop must stay quiet for 20 cycles.
        repeat (20) @(posedge clk);
        $display("test passed");
        $finish;
    end

    initial begin
        wait (budget != 0);
        #(budget * 100);
        fail_run("watchdog expired before all expected stores completed");
    end

endmodule

//--- riscv_lite.f
+incdir+src
src/isa_pkg.sv
src/core_pkg.sv
src/regfile_if.sv
src/decode_unit.sv
src/reg_file.sv
src/alu.sv
src/stage_reg.sv
src/cpu_core.sv
dv/cpu_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found on PATH"
    exit 1
fi

verilator --binary --timing -j 0 --top-module cpu_core_tb -f riscv_lite.f -o sim_cpu_core
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_cpu_core
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi
exit 0

//--- dv/cpu_patterns.txt
# I <word>: program in address order. D <addr> <data>: initial data word.
# S <addr> <data>: expected stores in order. C <n>: cycle budget. all hex except C.
D 00000100 f00000f5
D 00000104 00000043
D 00000108 00000003
I 10802703 # lw   x14, 0x108(x0)
I 10002083 # lw   x1, 0x100(x0)
I 10402103 # lw   x2, 0x104(x0)
I 002081b3 # add  x3, x1, x2
I 40208233 # sub  x4, x1, x2
I 002092b3 # sll  x5, x1, x2
I 0020a333 # slt  x6, x1, x2
I 0020b3b3 # sltu x7, x1, x2
I 0020c433 # xor  x8, x1, x2
I 0020d4b3 # srl  x9, x1, x2
I 4020d533 # sra  x10, x1, x2
I 0020e5b3 # or   x11, x1, x2
I 0020f633 # and  x12, x1, x2
I 20302023 # sw   x3, 0x200(x0)
I 20402223 # sw   x4, 0x204(x0)
I 20502423 # sw   x5, 0x208(x0)
I 20602623 # sw   x6, 0x20c(x0)
I 20702823 # sw   x7, 0x210(x0)
I 20802a23 # sw   x8, 0x214(x0)
I 20902c23 # sw   x9, 0x218(x0)
I 20a02e23 # sw   x10, 0x21c(x0)
I 22b02023 # sw   x11, 0x220(x0)
I 22c02223 # sw   x12, 0x224(x0)
I 002086b3 # add  x13, x1, x2
I 0016c6b3 # xor  x13, x13, x1
I 402686b3 # sub  x13, x13, x2
I 22d02423 # sw   x13, 0x228(x0)
I 00208033 # add  x0, x1, x2
I 22002623 # sw   x0, 0x22c(x0)
I 00208463 # beq  x1, x2, +8 not taken
I 22202823 # sw   x2, 0x230(x0)
I 00000663 # beq  x0, x0, +12 taken
I 22102a23 # sw   x1, 0x234(x0) squashed
I 22102c23 # sw   x1, 0x238(x0) squashed
I 24e02023 # loop sw x14, 0x240(x0)
I 40670733 # sub  x14, x14, x6
I 00070463 # beq  x14, x0, +8
I fe000ae3 # beq  x0, x0, -12
I 00000063 # beq  x0, x0, 0
S 00000200 f0000138
S 00000204 f00000b2
S 00000208 800007a8
S 0000020c 00000001
S 00000210 00000000
S 00000214 f00000b6
S 00000218 1e00001e
S 0000021c fe00001e
S 00000220 f00000f7
S 00000224 00000041
S 00000228 0000018a
S 0000022c 00000000
S 00000230 00000043
S 00000240 00000003
S 00000240 00000002
S 00000240 00000001
C 200
